// ==== aluSys.f ====
rtl/aluPkg.sv
rtl/aluBitSlice.sv
rtl/aluCore.sv
rtl/aluWbRegs.sv
rtl/aluTop.sv
tests/aluWb_checker.sv
tests/aluTb.sv

// ==== rtl/aluBitSlice.sv ====
`timescale 1ns/100ps

module aluBitSlice
    import aluPkg::*;
(
    input  aluOp op,
    input  logic a,
    input  logic b,
    input  logic carryIn,
    output logic res,
    output logic carryOut
);

    logic invertB;
    logic bEff;
    logic sum;
    logic sumCarry;

    // subtraction and compare both add the inverted operand
    assign invertB = (op == SUB) || (op == SLT);
    assign bEff    = b ^ invertB;

    // full adder
    assign sum      = a ^ bEff ^ carryIn;
    assign sumCarry = (a & bEff) | (carryIn & (a ^ bEff));

    always_comb begin
        res      = 1'b0;
        carryOut = 1'b0;
        case (op)
            ADD, SUB, SLT: begin
                res      = sum;
                carryOut = sumCarry;
            end
            XOR: begin
                res = a ^ b;
            end
            AND: begin
                res = a & b;
            end
            NAND: begin
                res = ~(a & b);
            end
            NOR: begin
                res = ~(a | b);
            end
            OR: begin
                res = a | b;
            end
            default: begin
                res      = 1'b0;
                carryOut = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/aluCore.sv ====
`timescale 1ns/100ps

module aluCore
    import aluPkg::*;
#(
    parameter int width = 32
) (
    input  aluOp               op,
    input  logic [width-1:0]   operandA,
    input  logic [width-1:0]   operandB,
    output logic [width-1:0]   result,
    output logic               carryout,
    output logic               zero,
    output logic               overflow
);

    // carry[i] feeds slice i, carry[width] leaves the top slice
    logic [width:0]   carry;
    logic [width-1:0] sliceRes;

    logic signA;
    logic signB;
    logic signRes;
    logic sameSigns;
    logic addOverflow;
    logic subOverflow;
    logic sltBit;

    // +1 completes the two's complement for SUB and SLT
    assign carry[0] = (op == SUB) || (op == SLT);

    for (genvar i = 0; i < width; i++) begin : gSlice
        aluBitSlice uSlice (
            .op       (op),
            .a        (operandA[i]),
            .b        (operandB[i]),
            .carryIn  (carry[i]),
            .res      (sliceRes[i]),
            .carryOut (carry[i+1])
        );
    end

    assign carryout = carry[width];

    assign signA     = operandA[width-1];
    assign signB     = operandB[width-1];
    assign signRes   = sliceRes[width-1];
    assign sameSigns = ~(signA ^ signB);

    // add overflows when like signs give a result of the other sign
    assign addOverflow = sameSigns & (signRes ^ signA);

    // sub overflows when unlike signs give a result whose sign differs from A
    assign subOverflow = ~sameSigns & (signRes ^ signA);

    always_comb begin
        case (op)
            ADD:     overflow = addOverflow;
            SUB:     overflow = subOverflow;
            default: overflow = 1'b0;
        endcase
    end

    // sign of A-B, flipped back when the difference wrapped
    assign sltBit = signRes ^ subOverflow;

    always_comb begin
        if (op == SLT) begin
            result = {{(width-1){1'b0}}, sltBit};
        end else begin
            result = sliceRes;
        end
    end

    assign zero = ~|result;

endmodule

// ==== rtl/aluPkg.sv ====
package aluPkg;

    // ALU commands as written into the command register
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        XOR  = 3'd2,
        SLT  = 3'd3,
        AND  = 3'd4,
        NAND = 3'd5,
        NOR  = 3'd6,
        OR   = 3'd7
    } aluOp;

    // word addresses on the Wishbone port
    typedef enum logic [2:0] {
        REG_A      = 3'd0,
        REG_B      = 3'd1,
        REG_CMD    = 3'd2,
        REG_RESULT = 3'd3,
        REG_FLAGS  = 3'd4
    } regAddr;

    // bit positions inside the flags word
    localparam int FLAG_CARRY = 0;
    localparam int FLAG_ZERO  = 1;
    localparam int FLAG_OVF   = 2;

endpackage

// ==== rtl/aluTop.sv ====
`timescale 1ns/100ps

module aluTop
    import aluPkg::*;
#(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [2:0]       adr,
    input  logic [width-1:0] datW,
    output logic [width-1:0] datR,
    output logic             ack
);

    logic [width-1:0] operandA;
    logic [width-1:0] operandB;
    aluOp             op;
    logic [width-1:0] result;
    logic             carryout;
    logic             zero;
    logic             overflow;

    // host side registers
    aluWbRegs #(
        .width (width)
    ) uRegs (
        .clk      (clk),
        .arstN    (arstN),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datW     (datW),
        .datR     (datR),
        .ack      (ack),
        .operandA (operandA),
        .operandB (operandB),
        .op       (op),
        .result   (result),
        .carryout (carryout),
        .zero     (zero),
        .overflow (overflow)
    );

    // combinational datapath
    aluCore #(
        .width (width)
    ) uCore (
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .result   (result),
        .carryout (carryout),
        .zero     (zero),
        .overflow (overflow)
    );

endmodule

// ==== rtl/aluWbRegs.sv ====
`timescale 1ns/100ps

module aluWbRegs
    import aluPkg::*;
#(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             arstN,
    // Wishbone classic slave
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [2:0]       adr,
    input  logic [width-1:0] datW,
    output logic [width-1:0] datR,
    output logic             ack,
    // towards the core
    output logic [width-1:0] operandA,
    output logic [width-1:0] operandB,
    output aluOp             op,
    input  logic [width-1:0] result,
    input  logic             carryout,
    input  logic             zero,
    input  logic             overflow
);

    regAddr           addr;
    logic             request;
    logic [2:0]       flags;
    logic [width-1:0] readData;

    assign addr = regAddr'(adr);

    // a new request is seen only while no ack is pending
    assign request = cyc & stb & ~ack;

    always_comb begin
        flags             = 3'b000;
        flags[FLAG_CARRY] = carryout;
        flags[FLAG_ZERO]  = zero;
        flags[FLAG_OVF]   = overflow;
    end

    // read mux, unmapped addresses return zero
    always_comb begin
        case (addr)
            REG_A:      readData = operandA;
            REG_B:      readData = operandB;
            REG_CMD:    readData = width'(op);
            REG_RESULT: readData = result;
            REG_FLAGS:  readData = width'(flags);
            default:    readData = '0;
        endcase
    end

    // single-cycle ack
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack <= 1'b0;
        end else begin
            ack <= request;
        end
    end

    // operand and command registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            operandA <= '0;
            operandB <= '0;
            op       <= ADD;
        end else if (request && we) begin
            case (addr)
                REG_A:   operandA <= datW;
                REG_B:   operandB <= datW;
                // only the low three bits hold the command
                REG_CMD: op <= aluOp'(datW[2:0]);
                default: begin
                end
            endcase
        end
    end

    // read data is captured with the request and held through ack
    always_ff @(posedge clk) begin
        if (request && !we) begin
            datR <= readData;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the ALU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f aluSys.f --top-module aluTb -o simAlu; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simAlu 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

// ==== tests/aluTb.sv ====
`timescale 1ns/100ps

module aluTb;
    import aluPkg::*;

    localparam int width      = 32;
    localparam int ackTimeout = 50;

    logic             clk;
    logic             arstN;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [2:0]       adr;
    logic [width-1:0] datW;
    logic [width-1:0] datR;
    logic             ack;

    integer seed;

    aluTop #(
        .width (width)
    ) DUT (
        .clk   (clk),
        .arstN (arstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datW  (datW),
        .datR  (datR),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input string testName, input logic [width-1:0] expected,
                              input logic [width-1:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", testName, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stopOnTimeout(input string what);
        $display("the DUT gave no ack within %0d cycles during %s", ackTimeout, what);
        $display("CHECKS FAILED");
        $fatal(1, "bus timeout");
    endtask

    // ack is sampled on the falling edge half a cycle after it settles
    task automatic waitForAck(input string what);
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        while (ack !== 1'b1) begin
            waitCycles++;
            if (waitCycles > ackTimeout) begin
                stopOnTimeout(what);
            end
            @(negedge clk);
        end
    endtask

    task automatic wbWrite(input regAddr addr, input logic [width-1:0] data);
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = 1'b1;
        adr  = addr;
        datW = data;
        waitForAck("a write");
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wbRead(input regAddr addr, output logic [width-1:0] data);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = addr;
        waitForAck("a read");
        data = datR;
        cyc  = 1'b0;
        stb  = 1'b0;
    endtask

    function automatic logic [width-1:0] randWord();
        return $random(seed);
    endfunction

    // expected result and flags word from the arithmetic definitions
    function automatic void aluModel(input aluOp op, input logic [width-1:0] a,
                                     input logic [width-1:0] b,
                                     output logic [width-1:0] res,
                                     output logic [width-1:0] flags);
        logic [width:0] sumWide;
        logic [width:0] diffWide;
        logic           carry;
        logic           ovf;
        sumWide  = {1'b0, a} + {1'b0, b};
        diffWide = {1'b0, a} + {1'b0, ~b} + {{width{1'b0}}, 1'b1};
        carry    = 1'b0;
        ovf      = 1'b0;
        case (op)
            ADD: begin
                res   = sumWide[width-1:0];
                carry = sumWide[width];
                ovf   = (a[width-1] == b[width-1]) && (res[width-1] != a[width-1]);
            end
            SUB: begin
                res   = diffWide[width-1:0];
                carry = diffWide[width];
                ovf   = (a[width-1] != b[width-1]) && (res[width-1] != a[width-1]);
            end
            SLT: begin
                res   = ($signed(a) < $signed(b)) ? {{(width-1){1'b0}}, 1'b1} : '0;
                carry = diffWide[width];
            end
            XOR:     res = a ^ b;
            AND:     res = a & b;
            NAND:    res = ~(a & b);
            NOR:     res = ~(a | b);
            OR:      res = a | b;
            default: res = '0;
        endcase
        flags             = '0;
        flags[FLAG_CARRY] = carry;
        flags[FLAG_ZERO]  = (res == '0);
        flags[FLAG_OVF]   = ovf;
    endfunction

    // one full host transaction sequence for a single operation
    task automatic runOp(input string testName, input aluOp op,
                         input logic [width-1:0] a, input logic [width-1:0] b);
        logic [width-1:0] expResult;
        logic [width-1:0] expFlags;
        logic [width-1:0] gotResult;
        logic [width-1:0] gotFlags;
        wbWrite(REG_A, a);
        wbWrite(REG_B, b);
        wbWrite(REG_CMD, width'(op));
        wbRead(REG_RESULT, gotResult);
        wbRead(REG_FLAGS, gotFlags);
        aluModel(op, a, b, expResult, expFlags);
        checkValue({testName, " result"}, expResult, gotResult);
        checkValue({testName, " flags"}, expFlags, gotFlags);
    endtask

    initial begin
        logic [width-1:0] a;
        logic [width-1:0] b;
        logic [width-1:0] cmd;
        logic [width-1:0] mask;
        logic [width-1:0] got;
        logic [width-1:0] zeroOnly;
        logic [width-1:0] corners [4];
        aluOp             logicOps [5];

        seed  = 32'h6d9e4dd5;
        // a strobe held during reset must not raise ack
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b0;
        adr   = 3'd0;
        datW  = '0;
        arstN = 1'b0;

        corners[0]  = '0;
        corners[1]  = '1;
        corners[2]  = {1'b0, {(width-1){1'b1}}};
        corners[3]  = {1'b1, {(width-1){1'b0}}};
        logicOps    = '{XOR, AND, NAND, NOR, OR};
        zeroOnly    = '0;
        zeroOnly[FLAG_ZERO] = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        cyc   = 1'b0;
        stb   = 1'b0;
        arstN = 1'b1;

        // reset state is an ADD of zero operands
        wbRead(REG_RESULT, got);
        checkValue("reset result", '0, got);
        wbRead(REG_FLAGS, got);
        checkValue("reset flags", zeroOnly, got);

        // register read-back
        for (int i = 0; i < 8; i++) begin
            a   = randWord();
            b   = randWord();
            cmd = randWord();
            wbWrite(REG_A, a);
            wbWrite(REG_B, b);
            wbWrite(REG_CMD, cmd);
            wbRead(REG_A, got);
            checkValue($sformatf("readback A #%0d", i), a, got);
            wbRead(REG_B, got);
            checkValue($sformatf("readback B #%0d", i), b, got);
            wbRead(REG_CMD, got);
            checkValue($sformatf("readback CMD #%0d", i), {{(width-3){1'b0}}, cmd[2:0]}, got);
        end

        // ADD and SUB with all corner pairs first
        for (int i = 0; i < 200; i++) begin
            if (i < 16) begin
                a = corners[i / 4];
                b = corners[i % 4];
            end else begin
                a = randWord();
                b = randWord();
            end
            runOp($sformatf("add #%0d", i), ADD, a, b);
            runOp($sformatf("sub #%0d", i), SUB, a, b);
        end

        // SLT with every fourth pair equal
        for (int i = 0; i < 60; i++) begin
            a = randWord();
            b = (i % 4 == 0) ? a : randWord();
            runOp($sformatf("slt #%0d", i), SLT, a, b);
        end
        for (int i = 0; i < 16; i++) begin
            runOp($sformatf("slt corner #%0d", i), SLT, corners[i / 4], corners[i % 4]);
        end

        // bitwise ops
        for (int j = 0; j < 5; j++) begin
            for (int i = 0; i < 20; i++) begin
                a = randWord();
                b = randWord();
                runOp($sformatf("%s #%0d", logicOps[j].name(), i), logicOps[j], a, b);
            end
        end

        // zero flag is set by equal operands and cleared by a nonzero result
        a = randWord();
        runOp("zero sub", SUB, a, a);
        wbRead(REG_FLAGS, got);
        checkValue("zero flag after sub", width'(1'b1), width'(got[FLAG_ZERO]));
        runOp("zero xor", XOR, a, a);
        wbRead(REG_FLAGS, got);
        checkValue("zero flag after xor", width'(1'b1), width'(got[FLAG_ZERO]));
        mask    = randWord();
        mask[0] = 1'b1;
        runOp("nonzero xor", XOR, a, a ^ mask);
        wbRead(REG_FLAGS, got);
        checkValue("zero flag cleared", '0, width'(got[FLAG_ZERO]));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tests/aluWb_checker.sv ====
`timescale 1ns/100ps

module aluWbChecker (
    input logic clk,
    input logic arstN,
    input logic cyc,
    input logic stb,
    input logic ack
);

    // ack answers a strobe sampled on the previous edge
    ackFollowsRequest: assert property (
        @(posedge clk) disable iff (!arstN)
        ack |-> $past(cyc && stb)
    ) else $error("ack raised without cyc and stb on the previous edge");

    // single-cycle ack
    ackOneCycle: assert property (
        @(posedge clk) disable iff (!arstN)
        ack |=> !ack
    ) else $error("ack held high for two cycles");

    // no bus response while reset is applied
    ackLowInReset: assert property (
        @(posedge clk)
        !arstN |-> !ack
    ) else $error("ack high during reset");

endmodule

bind aluWbRegs aluWbChecker uWbChecker (
    .clk   (clk),
    .arstN (arstN),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack)
);
